//--- logic/rob_pkg.sv
// reorder buffer package
// sizes, commit id and slot mask types, exception codes
// and the layout of one ring entry

package rob_pkg;

  // ------------------------------
  // sizes
  // ------------------------------
  localparam int DISP_SIZE   = 2;             // instructions per group
  localparam int ROB_ENTRIES = 8;             // ring depth
  localparam int ENTRY_W     = 3;             // ring index bits
  localparam int CMT_ID_W    = ENTRY_W + 1;   // index plus wrap bit
  localparam int PC_W        = 30;            // word pc, byte address >> 2
  localparam int SLOT_W      = (DISP_SIZE > 1) ? $clog2(DISP_SIZE) : 1;

  // ------------------------------
  // basic types
  // ------------------------------
  typedef logic [DISP_SIZE-1:0] grp_t;     // one bit per slot
  typedef logic [CMT_ID_W-1:0]  cmt_id_t;
  typedef logic [3:0]           except_t;

  // exception codes, riscv cause numbering
  localparam except_t INST_ACC_FAULT = 4'd1;
  localparam except_t ILLEGAL_INST   = 4'd2;
  localparam except_t LOAD_FAULT     = 4'd5;
  localparam except_t STORE_FAULT    = 4'd7;
  localparam except_t ECALL          = 4'd11;

  // ------------------------------
  // ring entry
  // ------------------------------
  // done_grp_id has slots outside the group already set,
  // so an entry is complete when the whole mask is ones
  typedef struct packed {
    logic                    valid;
    logic [PC_W-1:0]         pc;            // base pc of the group
    grp_t                    grp_id;        // live slots
    grp_t                    done_grp_id;
    grp_t                    except_valid;
    except_t [DISP_SIZE-1:0] except_type;   // per slot
  } rob_entry_t;

endpackage

//--- logic/rob_alloc_if.sv
// allocation interface
// carries a newly built entry from dispatch into the ring

interface rob_alloc_if;
  import rob_pkg::*;

  logic       valid;   // dispatch strobe
  rob_entry_t entry;   // entry to be written at the in pointer

  // dispatch side
  modport producer (
    output valid,
    output entry
  );

  // storage side
  modport ring (
    input valid,
    input entry
  );

endinterface

//--- logic/rob_head_if.sv
// head interface
// oldest entry from the ring to the commit selector,
// flush request back to the ring

interface rob_head_if;
  import rob_pkg::*;

  logic       head_done;     // all live slots of the head are done
  cmt_id_t    head_cmt_id;
  rob_entry_t head_entry;
  logic       flush;         // excepting commit, clear the ring

  modport ring (
    output head_done,
    output head_cmt_id,
    output head_entry,
    input  flush
  );

  modport commit (
    input  head_done,
    input  head_cmt_id,
    input  head_entry,
    output flush
  );

endinterface

//--- logic/rob_dispatch.sv
// dispatch entry builder
// turns a dispatched group and its early exceptions into a ring entry

module rob_dispatch (
  input  logic                                        i_disp_valid,
  input  logic [rob_pkg::PC_W-1:0]                    i_disp_pc,
  input  rob_pkg::grp_t                               i_disp_grp_id,
  input  rob_pkg::grp_t                               i_disp_except_valid,
  input  rob_pkg::except_t [rob_pkg::DISP_SIZE-1:0]   i_disp_except_type,
  rob_alloc_if.producer                               alloc
);
  import rob_pkg::*;

  grp_t       w_early_exc;   // early exceptions on live slots only
  rob_entry_t w_entry;

  // ------------------------------
  // exception mask
  // ------------------------------
  // fetch faults and illegal opcodes found before execution
  assign w_early_exc = i_disp_except_valid & i_disp_grp_id;

  // ------------------------------
  // entry assembly
  // ------------------------------
  always_comb begin
    w_entry              = '0;
    w_entry.valid        = i_disp_valid;
    w_entry.pc           = i_disp_pc;
    w_entry.grp_id       = i_disp_grp_id;
    w_entry.except_valid = w_early_exc;

    // an excepting slot never reaches an execution unit, so it is done now;
    // empty slots count as done too
    w_entry.done_grp_id  = w_early_exc | ~i_disp_grp_id;

    for (int d = 0; d < DISP_SIZE; d++) begin
      if (w_early_exc[d]) begin
        w_entry.except_type[d] = i_disp_except_type[d];
      end else begin
        w_entry.except_type[d] = '0;   // no stale code on clean slots
      end
    end
  end

  // ------------------------------
  // to the ring
  // ------------------------------
  assign alloc.valid = i_disp_valid;
  assign alloc.entry = w_entry;

endmodule

//--- logic/rob_ring.sv
// entry ring of the reorder buffer
// in and out commit id pointers, full detection,
// completion tracking, head retire and flush

module rob_ring (
  input  logic             i_clk,
  input  logic             i_reset_n,

  rob_alloc_if.ring        alloc,

  input  logic             i_done_valid,
  input  rob_pkg::cmt_id_t i_done_cmt_id,
  input  rob_pkg::grp_t    i_done_grp_id,        // one-hot slot
  input  logic             i_done_except_valid,
  input  rob_pkg::except_t i_done_except_type,

  output logic             o_disp_ready,
  output rob_pkg::cmt_id_t o_new_cmt_id,

  rob_head_if.ring         head
);
  import rob_pkg::*;

  rob_entry_t             r_entries [ROB_ENTRIES];   // payload
  logic [ROB_ENTRIES-1:0] r_valid;
  cmt_id_t                r_in_cmt_id;               // next id handed out
  cmt_id_t                r_out_cmt_id;              // oldest entry

  logic [ENTRY_W-1:0]     w_in_idx;
  logic [ENTRY_W-1:0]     w_out_idx;
  logic [ENTRY_W-1:0]     w_done_idx;
  cmt_id_t                w_count;                   // live entries, 0 to 8
  cmt_id_t                w_done_age;                // distance from the head
  logic                   w_full;
  logic                   w_push;
  logic                   w_pop;
  logic                   w_done_hit;
  rob_entry_t             w_head_entry;

  assign w_in_idx   = r_in_cmt_id[ENTRY_W-1:0];
  assign w_out_idx  = r_out_cmt_id[ENTRY_W-1:0];
  assign w_done_idx = i_done_cmt_id[ENTRY_W-1:0];

  // ------------------------------
  // occupancy
  // ------------------------------
  assign w_count      = r_in_cmt_id - r_out_cmt_id;   // wrap bit makes 8 distinct from 0
  assign w_full       = (w_count == CMT_ID_W'(ROB_ENTRIES));
  assign o_disp_ready = ~w_full;
  assign o_new_cmt_id = r_in_cmt_id;

  assign w_push = alloc.valid & ~w_full & ~head.flush;
  assign w_pop  = head.head_done;

  // report must name an id between out and in
  assign w_done_age = i_done_cmt_id - r_out_cmt_id;
  assign w_done_hit = i_done_valid & ~head.flush & (w_done_age < w_count) &
                      r_valid[w_done_idx];

  // ------------------------------
  // head presentation
  // ------------------------------
  always_comb begin
    w_head_entry       = r_entries[w_out_idx];
    w_head_entry.valid = r_valid[w_out_idx];
  end

  assign head.head_entry  = w_head_entry;
  assign head.head_cmt_id = r_out_cmt_id;
  assign head.head_done   = w_head_entry.valid & (&w_head_entry.done_grp_id);

  // ------------------------------
  // pointers and valid bits
  // ------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid      <= '0;
      r_in_cmt_id  <= '0;
      r_out_cmt_id <= '0;
    end else if (head.flush) begin
      // the flushing head commits, everything younger is dropped
      r_valid      <= '0;
      r_in_cmt_id  <= r_out_cmt_id + 1'b1;
      r_out_cmt_id <= r_out_cmt_id + 1'b1;
    end else begin
      if (w_push) begin
        r_valid[w_in_idx] <= 1'b1;
        r_in_cmt_id       <= r_in_cmt_id + 1'b1;
      end
      if (w_pop) begin
        r_valid[w_out_idx] <= 1'b0;
        r_out_cmt_id       <= r_out_cmt_id + 1'b1;
      end
    end
  end

  // ------------------------------
  // entry payload
  // ------------------------------
  // a push never targets a valid index, so it cannot collide with a report
  always_ff @(posedge i_clk) begin
    if (w_push) begin
      r_entries[w_in_idx] <= alloc.entry;
    end
    if (w_done_hit) begin
      r_entries[w_done_idx].done_grp_id <= r_entries[w_done_idx].done_grp_id |
                                           i_done_grp_id;
      if (i_done_except_valid) begin
        r_entries[w_done_idx].except_valid <= r_entries[w_done_idx].except_valid |
                                              (i_done_grp_id & r_entries[w_done_idx].grp_id);
        for (int d = 0; d < DISP_SIZE; d++) begin
          if (i_done_grp_id[d]) begin
            r_entries[w_done_idx].except_type[d] <= i_done_except_type;
          end
        end
      end
    end
  end

endmodule

//--- logic/rob_commit.sv
// commit selector
// picks the lowest excepting slot of the head group, builds the dead mask,
// the exception pc and the flush request

module rob_commit (
  rob_head_if.commit                  head,

  output logic                        o_commit,
  output rob_pkg::cmt_id_t            o_commit_cmt_id,
  output rob_pkg::grp_t               o_commit_grp_id,
  output rob_pkg::grp_t               o_commit_dead_id,
  output logic                        o_commit_except_valid,
  output rob_pkg::except_t            o_commit_except_type,
  output logic [rob_pkg::PC_W+1:0]    o_commit_epc            // byte pc
);
  import rob_pkg::*;

  grp_t              w_exc;
  logic              w_exc_any;
  logic [SLOT_W-1:0] w_exc_slot;   // lowest excepting slot
  except_t           w_exc_type;
  grp_t              w_dead_id;

  assign w_exc     = head.head_entry.except_valid;
  assign w_exc_any = |w_exc;

  // ------------------------------
  // slot selection and dead mask
  // ------------------------------
  always_comb begin : sel_blk
    logic seen;   // an excepting slot lies below
    seen       = 1'b0;
    w_exc_slot = '0;
    w_exc_type = '0;
    w_dead_id  = '0;
    for (int d = 0; d < DISP_SIZE; d++) begin
      // the excepting slot itself stays live
      w_dead_id[d] = seen & head.head_entry.grp_id[d];
      if (w_exc[d] & ~seen) begin
        w_exc_slot = SLOT_W'(d);
        w_exc_type = head.head_entry.except_type[d];
      end
      seen = seen | w_exc[d];
    end
  end

  // ------------------------------
  // commit outputs
  // ------------------------------
  assign o_commit              = head.head_done;
  assign o_commit_cmt_id       = head.head_cmt_id;
  assign o_commit_grp_id       = head.head_entry.grp_id;
  assign o_commit_dead_id      = w_dead_id;
  assign o_commit_except_valid = w_exc_any;
  assign o_commit_except_type  = w_exc_type;

  // base pc plus 4 per slot
  assign o_commit_epc = {head.head_entry.pc + PC_W'(w_exc_slot), 2'b00};

  // excepting commit empties the ring at the next edge
  assign head.flush = head.head_done & w_exc_any;

endmodule

//--- logic/rob_top.sv
// reorder buffer top level
// dispatch entry builder, entry ring and commit selector on plain ports

module rob_top (
  input  logic                                        i_clk,
  input  logic                                        i_reset_n,

  // dispatch
  input  logic                                        i_disp_valid,
  input  logic [rob_pkg::PC_W-1:0]                    i_disp_pc,
  input  rob_pkg::grp_t                               i_disp_grp_id,
  input  rob_pkg::grp_t                               i_disp_except_valid,
  input  rob_pkg::except_t [rob_pkg::DISP_SIZE-1:0]   i_disp_except_type,
  output logic                                        o_disp_ready,
  output rob_pkg::cmt_id_t                            o_new_cmt_id,

  // completion
  input  logic                                        i_done_valid,
  input  rob_pkg::cmt_id_t                            i_done_cmt_id,
  input  rob_pkg::grp_t                               i_done_grp_id,
  input  logic                                        i_done_except_valid,
  input  rob_pkg::except_t                            i_done_except_type,

  // commit
  output logic                                        o_commit,
  output rob_pkg::cmt_id_t                            o_commit_cmt_id,
  output rob_pkg::grp_t                               o_commit_grp_id,
  output rob_pkg::grp_t                               o_commit_dead_id,
  output logic                                        o_commit_except_valid,
  output rob_pkg::except_t                            o_commit_except_type,
  output logic [rob_pkg::PC_W+1:0]                    o_commit_epc
);

  rob_alloc_if alloc_if ();
  rob_head_if  head_if ();

  rob_dispatch u_dispatch (
    .i_disp_valid        (i_disp_valid),
    .i_disp_pc           (i_disp_pc),
    .i_disp_grp_id       (i_disp_grp_id),
    .i_disp_except_valid (i_disp_except_valid),
    .i_disp_except_type  (i_disp_except_type),
    .alloc               (alloc_if.producer)
  );

  rob_ring u_ring (
    .i_clk               (i_clk),
    .i_reset_n           (i_reset_n),
    .alloc               (alloc_if.ring),
    .i_done_valid        (i_done_valid),
    .i_done_cmt_id       (i_done_cmt_id),
    .i_done_grp_id       (i_done_grp_id),
    .i_done_except_valid (i_done_except_valid),
    .i_done_except_type  (i_done_except_type),
    .o_disp_ready        (o_disp_ready),
    .o_new_cmt_id        (o_new_cmt_id),
    .head                (head_if.ring)
  );

  rob_commit u_commit (
    .head                  (head_if.commit),
    .o_commit              (o_commit),
    .o_commit_cmt_id       (o_commit_cmt_id),
    .o_commit_grp_id       (o_commit_grp_id),
    .o_commit_dead_id      (o_commit_dead_id),
    .o_commit_except_valid (o_commit_except_valid),
    .o_commit_except_type  (o_commit_except_type),
    .o_commit_epc          (o_commit_epc)
  );

endmodule

//--- test/tb_clock.sv
// testbench clock and reset
// free running clock, reset held low for a few cycles

module tb_clock #(
  parameter int PERIOD_NS    = 4,
  parameter int RESET_CYCLES = 3
) (
  output logic o_clk,
  output logic o_reset_n
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    o_clk     = 1'b0;
    o_reset_n = 1'b0;
    forever #(PERIOD_NS / 2.0) o_clk = ~o_clk;
  end

  initial begin
    repeat (RESET_CYCLES) @(posedge o_clk);
    o_reset_n <= 1'b1;   // released on a rising edge
  end

endmodule

//--- test/rob_checker.sv
// commit checker
// reference model of the ring built from the dispatch, completion and commit rules
// and its comparison with the DUT outputs at every falling edge

module rob_checker (
  input  logic                                      i_clk,
  input  logic                                      i_reset_n,
  input  logic                                      i_disp_valid,
  input  logic [rob_pkg::PC_W-1:0]                  i_disp_pc,
  input  rob_pkg::grp_t                             i_disp_grp_id,
  input  rob_pkg::grp_t                             i_disp_except_valid,
  input  rob_pkg::except_t [rob_pkg::DISP_SIZE-1:0] i_disp_except_type,
  input  logic                                      i_done_valid,
  input  rob_pkg::cmt_id_t                          i_done_cmt_id,
  input  rob_pkg::grp_t                             i_done_grp_id,
  input  logic                                      i_done_except_valid,
  input  rob_pkg::except_t                          i_done_except_type,
  input  logic                                      i_ready,
  input  rob_pkg::cmt_id_t                          i_new_cmt_id,
  input  logic                                      i_commit,
  input  rob_pkg::cmt_id_t                          i_commit_cmt_id,
  input  rob_pkg::grp_t                             i_commit_grp_id,
  input  rob_pkg::grp_t                             i_commit_dead_id,
  input  logic                                      i_commit_except_valid,
  input  rob_pkg::except_t                          i_commit_except_type,
  input  logic [rob_pkg::PC_W+1:0]                  i_commit_epc,
  output int                                        o_checks,
  output int                                        o_errors,
  output int                                        o_commits,
  output int                                        o_pending
);
  timeunit 1ns;
  timeprecision 100ps;
  import rob_pkg::*;

  logic [PC_W-1:0]         m_pc   [ROB_ENTRIES];
  grp_t                    m_grp  [ROB_ENTRIES];
  grp_t                    m_done [ROB_ENTRIES];   // empty slots count as done
  grp_t                    m_exc  [ROB_ENTRIES];
  except_t [DISP_SIZE-1:0] m_type [ROB_ENTRIES];
  logic [ROB_ENTRIES-1:0]  m_valid;
  cmt_id_t                 m_in;
  cmt_id_t                 m_out;

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    o_checks = o_checks + 1;
    if (got !== exp) begin
      o_errors = o_errors + 1;
      $display("Mismatch at %0d ns: %s is %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  always @(negedge i_clk) begin : model_blk
    int      idx;
    int      di;
    int      slot;        // lowest excepting slot or -1 when clean
    logic    head_done;
    grp_t    dead;
    cmt_id_t fill;
    cmt_id_t age;
    if (!i_reset_n) begin
      m_valid = '0;
      m_in    = '0;
      m_out   = '0;
    end else begin
      fill      = m_in - m_out;
      idx       = m_out[ENTRY_W-1:0];
      head_done = m_valid[idx] && (m_done[idx] == '1);
      slot      = -1;
      dead      = '0;
      for (int d = 0; d < DISP_SIZE; d++) begin
        if (slot >= 0) begin
          dead[d] = m_grp[idx][d];   // above the excepting slot
        end
        if (slot < 0 && m_exc[idx][d]) begin
          slot = d;
        end
      end

      // ------------------------------
      // outputs against the model
      // ------------------------------
      compare_value("o_disp_ready", i_ready, fill != ROB_ENTRIES);
      compare_value("o_new_cmt_id", i_new_cmt_id, m_in);
      compare_value("o_commit", i_commit, head_done);
      if (head_done) begin
        o_commits = o_commits + 1;
        compare_value("o_commit_cmt_id", i_commit_cmt_id, m_out);
        compare_value("o_commit_grp_id", i_commit_grp_id, m_grp[idx]);
        compare_value("o_commit_dead_id", i_commit_dead_id, dead);
        compare_value("o_commit_except_valid", i_commit_except_valid, slot >= 0);
        if (slot >= 0) begin
          compare_value("o_commit_except_type", i_commit_except_type, m_type[idx][slot]);
          compare_value("o_commit_epc", i_commit_epc, {m_pc[idx], 2'b00} + 4 * slot);
        end
      end

      // ------------------------------
      // state after the next rising edge
      // ------------------------------
      if (head_done && slot >= 0) begin
        m_valid = '0;               // flush drops same-cycle strobes
        m_out   = m_out + 1'b1;
        m_in    = m_out;
      end else begin
        age = i_done_cmt_id - m_out;
        if (i_done_valid && age < fill && m_valid[i_done_cmt_id[ENTRY_W-1:0]]) begin
          di         = i_done_cmt_id[ENTRY_W-1:0];
          m_done[di] = m_done[di] | i_done_grp_id;
          if (i_done_except_valid) begin
            m_exc[di] = m_exc[di] | (i_done_grp_id & m_grp[di]);
            for (int d = 0; d < DISP_SIZE; d++) begin
              if (i_done_grp_id[d]) begin
                m_type[di][d] = i_done_except_type;
              end
            end
          end
        end
        if (i_disp_valid && fill != ROB_ENTRIES) begin
          di          = m_in[ENTRY_W-1:0];
          m_valid[di] = 1'b1;
          m_pc[di]    = i_disp_pc;
          m_grp[di]   = i_disp_grp_id;
          m_exc[di]   = i_disp_except_valid & i_disp_grp_id;
          m_done[di]  = m_exc[di] | ~i_disp_grp_id;   // early exception means done
          for (int d = 0; d < DISP_SIZE; d++) begin
            m_type[di][d] = m_exc[di][d] ? i_disp_except_type[d] : 4'd0;
          end
          m_in = m_in + 1'b1;
        end
        if (head_done) begin
          m_valid[idx] = 1'b0;
          m_out        = m_out + 1'b1;
        end
      end
    end
    o_pending = cmt_id_t'(m_in - m_out);
  end

endmodule

//--- test/rob_tb.sv
// reorder buffer testbench
// stimulus table applied in a loop with random idle gaps,
// timeout counter, clock, DUT and commit checker

module rob_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import rob_pkg::*;

  localparam int IDLE      = 0;
  localparam int DISP      = 1;
  localparam int DONE      = 2;
  localparam int NUM_TESTS = 5;

  // for a completion, mask is the slot and a nonzero exc flags an exception
  typedef struct {
    int              kind;
    int              test;
    int              tag;     // group name, bound to a commit id at dispatch
    logic [PC_W-1:0] pc;
    grp_t            mask;
    grp_t            exc;
    except_t         etype;
  } row_t;

  logic                    i_clk;
  logic                    i_reset_n;
  logic                    i_disp_valid;
  logic [PC_W-1:0]         i_disp_pc;
  grp_t                    i_disp_grp_id;
  grp_t                    i_disp_except_valid;
  except_t [DISP_SIZE-1:0] i_disp_except_type;
  logic                    o_disp_ready;
  cmt_id_t                 o_new_cmt_id;
  logic                    i_done_valid;
  cmt_id_t                 i_done_cmt_id;
  grp_t                    i_done_grp_id;
  logic                    i_done_except_valid;
  except_t                 i_done_except_type;
  logic                    o_commit;
  cmt_id_t                 o_commit_cmt_id;
  grp_t                    o_commit_grp_id;
  grp_t                    o_commit_dead_id;
  logic                    o_commit_except_valid;
  except_t                 o_commit_except_type;
  logic [PC_W+1:0]         o_commit_epc;
  int                      checks;
  int                      errors;
  int                      commits;
  int                      pending;

  row_t        rows [$];
  cmt_id_t     tag_id [32];
  logic [31:0] lfsr_state;
  int          cycles;
  int          limit;

  tb_clock #(.PERIOD_NS(4), .RESET_CYCLES(3)) clock_i (.o_clk(i_clk), .o_reset_n(i_reset_n));

  rob_top rob_top_i (.*);

  rob_checker checker_i (
    .*,
    .i_ready               (o_disp_ready),
    .i_new_cmt_id          (o_new_cmt_id),
    .i_commit              (o_commit),
    .i_commit_cmt_id       (o_commit_cmt_id),
    .i_commit_grp_id       (o_commit_grp_id),
    .i_commit_dead_id      (o_commit_dead_id),
    .i_commit_except_valid (o_commit_except_valid),
    .i_commit_except_type  (o_commit_except_type),
    .i_commit_epc          (o_commit_epc),
    .o_checks              (checks),
    .o_errors              (errors),
    .o_commits             (commits),
    .o_pending             (pending)
  );

  always @(posedge i_clk) begin
    cycles = cycles + 1;
    if (limit > 0 && cycles > limit) begin
      $display("timeout after %0d cycles, the DUT stopped making progress", cycles);
      $display("Result: FAILED");
      $finish;
    end
  end

  // right shift Galois LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic draw_gap(output int gap);
    gap = 0;
    repeat (2) begin
      gap        = (gap << 1) | lfsr_state[0];   // one step per bit
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  task automatic add_row(input int kind, input int test, input int tag,
                         input logic [PC_W-1:0] pc, input grp_t mask, input grp_t exc,
                         input except_t etype);
    row_t r;
    r = '{kind, test, tag, pc, mask, exc, etype};
    rows.push_back(r);
  endtask

  // ------------------------------
  // stimulus table
  // ------------------------------
  task automatic build_table();
    add_row(IDLE, 1, 0, 30'h000, 2'b00, 2'b00, 4'd0);
    add_row(IDLE, 1, 0, 30'h000, 2'b00, 2'b00, 4'd0);
    // completion out of order
    add_row(DISP, 2, 0, 30'h100, 2'b11, 2'b00, 4'd0);
    add_row(DISP, 2, 1, 30'h104, 2'b01, 2'b00, 4'd0);
    add_row(DISP, 2, 2, 30'h108, 2'b10, 2'b00, 4'd0);
    add_row(DONE, 2, 2, 30'h000, 2'b10, 2'b00, 4'd0);
    add_row(DONE, 2, 1, 30'h000, 2'b01, 2'b00, 4'd0);
    add_row(DONE, 2, 0, 30'h000, 2'b10, 2'b00, 4'd0);
    add_row(DONE, 2, 0, 30'h000, 2'b01, 2'b00, 4'd0);
    // early exception on slot 1, later one on slot 0
    add_row(DISP, 3, 3, 30'h200, 2'b11, 2'b10, ILLEGAL_INST);
    add_row(DONE, 3, 3, 30'h000, 2'b01, 2'b01, LOAD_FAULT);
    add_row(DISP, 3, 4, 30'h240, 2'b01, 2'b01, ECALL);
    // flush drops younger groups
    add_row(DISP, 4, 5, 30'h300, 2'b11, 2'b00, 4'd0);
    add_row(DISP, 4, 6, 30'h304, 2'b11, 2'b00, 4'd0);
    add_row(DISP, 4, 7, 30'h308, 2'b01, 2'b00, 4'd0);
    add_row(DONE, 4, 6, 30'h000, 2'b01, 2'b00, 4'd0);
    add_row(DONE, 4, 6, 30'h000, 2'b10, 2'b00, 4'd0);
    add_row(DONE, 4, 7, 30'h000, 2'b01, 2'b00, 4'd0);
    add_row(DONE, 4, 5, 30'h000, 2'b10, 2'b10, STORE_FAULT);
    add_row(DONE, 4, 5, 30'h000, 2'b01, 2'b00, 4'd0);
    add_row(IDLE, 4, 0, 30'h000, 2'b00, 2'b00, 4'd0);
    add_row(DISP, 4, 8, 30'h400, 2'b01, 2'b00, 4'd0);
    add_row(DONE, 4, 8, 30'h000, 2'b01, 2'b00, 4'd0);
    // fill all eight entries, then wrap the ids
    for (int t = 9; t <= 16; t++) begin
      add_row(DISP, 5, t, 30'h500 + 30'(t), 2'b01, 2'b00, 4'd0);
    end
    add_row(DONE, 5, 9, 30'h000, 2'b01, 2'b00, 4'd0);
    add_row(DISP, 5, 17, 30'h520, 2'b01, 2'b00, 4'd0);
    add_row(DONE, 5, 10, 30'h000, 2'b01, 2'b01, INST_ACC_FAULT);
  endtask

  task automatic apply_row(input row_t r);
    int gap;
    @(negedge i_clk);
    while (r.kind == DISP && !o_disp_ready) begin
      @(negedge i_clk);
    end
    if (r.kind == DISP) begin
      tag_id[r.tag] = o_new_cmt_id;
    end
    @(posedge i_clk);
    i_disp_valid        <= (r.kind == DISP);
    i_disp_pc           <= r.pc;
    i_disp_grp_id       <= r.mask;
    i_disp_except_valid <= r.exc;
    i_disp_except_type  <= {DISP_SIZE{r.etype}};
    i_done_valid        <= (r.kind == DONE);
    i_done_cmt_id       <= tag_id[r.tag];
    i_done_grp_id       <= r.mask;
    i_done_except_valid <= (r.exc != '0);
    i_done_except_type  <= r.etype;
    @(posedge i_clk);
    i_disp_valid <= 1'b0;
    i_done_valid <= 1'b0;
    draw_gap(gap);
    repeat (gap) @(posedge i_clk);
  endtask

  task automatic finish_test(input int test, input int err_mark, input int cmt_mark);
    @(posedge i_clk);
    while (pending != 0) begin
      @(posedge i_clk);   // drain the ring
    end
    $display("test %0d done: %0d commits, %0d errors", test, commits - cmt_mark,
             errors - err_mark);
  endtask

  initial begin
    int cur_test;
    int err_mark;
    int cmt_mark;
    i_disp_valid        = 1'b0;
    i_disp_pc           = '0;
    i_disp_grp_id       = '0;
    i_disp_except_valid = '0;
    i_disp_except_type  = '0;
    i_done_valid        = 1'b0;
    i_done_cmt_id       = '0;
    i_done_grp_id       = '0;
    i_done_except_valid = 1'b0;
    i_done_except_type  = '0;
    lfsr_state          = 32'hdb1d_7540;
    cycles              = 0;
    limit               = 0;
    build_table();
    limit    = rows.size() * 8 + 50;
    wait (i_reset_n === 1'b1);
    cur_test = rows[0].test;
    err_mark = 0;
    cmt_mark = 0;
    foreach (rows[k]) begin
      if (rows[k].test != cur_test) begin
        finish_test(cur_test, err_mark, cmt_mark);
        cur_test = rows[k].test;
        err_mark = errors;
        cmt_mark = commits;
      end
      apply_row(rows[k]);
    end
    finish_test(cur_test, err_mark, cmt_mark);
    $display("%0d tests, %0d checks, %0d commits, %0d errors", NUM_TESTS, checks, commits,
             errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

//--- rob_top.f
logic/rob_pkg.sv
logic/rob_alloc_if.sv
logic/rob_head_if.sv
logic/rob_dispatch.sv
logic/rob_ring.sv
logic/rob_commit.sv
logic/rob_top.sv
test/tb_clock.sv
test/rob_checker.sv
test/rob_tb.sv
